// File: common/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and register file size
  ////////////////////////////////////////////////////////////////////////////
  localparam int NB_DATA     = 32;
  localparam int N_REGS      = 32;
  localparam int NB_REG_ADDR = $clog2(N_REGS);
  localparam int NB_OPCODE   = 6;
  localparam int NB_SHAMT    = 5;
  localparam int NB_IMM      = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [NB_OPCODE-1:0]   opcode;
    logic [NB_REG_ADDR-1:0] rs;
    logic [NB_REG_ADDR-1:0] rt;
    logic [NB_REG_ADDR-1:0] rd;
    logic [NB_SHAMT-1:0]    shamt;
    logic [NB_OPCODE-1:0]   funct;
  } r_format_t;

  typedef struct packed {
    logic [NB_OPCODE-1:0]   opcode;
    logic [NB_REG_ADDR-1:0] rs;
    logic [NB_REG_ADDR-1:0] rt;
    logic [NB_IMM-1:0]      imm;
  } i_format_t;

  // Low half is rd/shamt/funct or the immediate, depending on opcode
  typedef union packed {
    r_format_t r_fmt;
    i_format_t i_fmt;
  } instr_u;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////////////////////
  localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
  localparam logic [NB_OPCODE-1:0] OP_J     = 6'h02;
  localparam logic [NB_OPCODE-1:0] OP_BEQ   = 6'h04;
  localparam logic [NB_OPCODE-1:0] OP_BNE   = 6'h05;
  localparam logic [NB_OPCODE-1:0] OP_ADDI  = 6'h08;
  localparam logic [NB_OPCODE-1:0] OP_SLTI  = 6'h0a;
  localparam logic [NB_OPCODE-1:0] OP_ANDI  = 6'h0c;
  localparam logic [NB_OPCODE-1:0] OP_ORI   = 6'h0d;
  localparam logic [NB_OPCODE-1:0] OP_XORI  = 6'h0e;
  localparam logic [NB_OPCODE-1:0] OP_LUI   = 6'h0f;
  localparam logic [NB_OPCODE-1:0] OP_LW    = 6'h23;
  localparam logic [NB_OPCODE-1:0] OP_SW    = 6'h2b;

  // R-type function codes
  localparam logic [NB_OPCODE-1:0] FN_SLL = 6'h00;
  localparam logic [NB_OPCODE-1:0] FN_SRL = 6'h02;
  localparam logic [NB_OPCODE-1:0] FN_SRA = 6'h03;
  localparam logic [NB_OPCODE-1:0] FN_JR  = 6'h08;
  localparam logic [NB_OPCODE-1:0] FN_ADD = 6'h20;
  localparam logic [NB_OPCODE-1:0] FN_SUB = 6'h22;
  localparam logic [NB_OPCODE-1:0] FN_AND = 6'h24;
  localparam logic [NB_OPCODE-1:0] FN_OR  = 6'h25;
  localparam logic [NB_OPCODE-1:0] FN_XOR = 6'h26;
  localparam logic [NB_OPCODE-1:0] FN_NOR = 6'h27;
  localparam logic [NB_OPCODE-1:0] FN_SLT = 6'h2a;

endpackage

`default_nettype wire

// File: common/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // ALU operation seen by the execute stage
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_NOR = 4'd5,
    ALU_SLT = 4'd6,
    ALU_SLL = 4'd7,
    ALU_SRL = 4'd8,
    ALU_SRA = 4'd9,
    ALU_LUI = 4'd10
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Control groups, one per consuming stage
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic reg_write;
    logic mem_to_reg;
  } ctrl_wb_t;

  typedef struct packed {
    logic branch;
    logic branch_ne;
    logic mem_read;
    logic mem_write;
  } ctrl_mem_t;

  typedef struct packed {
    logic    reg_dst;
    logic    alu_src;
    logic    jump;
    logic    jump_reg;
    alu_op_e alu_op;
  } ctrl_ex_t;

  typedef struct packed {
    ctrl_wb_t  wb;
    ctrl_mem_t mem;
    ctrl_ex_t  ex;
  } ctrl_t;

  // ID/EX pipeline register contents
  typedef struct packed {
    logic                                valid;
    logic                                illegal;
    logic [mips_isa_pkg::NB_DATA-1:0]     pc_plus4;
    logic [mips_isa_pkg::NB_REG_ADDR-1:0] rs;
    logic [mips_isa_pkg::NB_REG_ADDR-1:0] rt;
    logic [mips_isa_pkg::NB_REG_ADDR-1:0] rd;
    logic [mips_isa_pkg::NB_SHAMT-1:0]    shamt;
    logic [mips_isa_pkg::NB_DATA-1:0]     dato1;
    logic [mips_isa_pkg::NB_DATA-1:0]     dato2;
    logic [mips_isa_pkg::NB_DATA-1:0]     imm_ext;
    ctrl_t                               ctrl;
  } id_ex_t;

endpackage

`default_nettype wire

// File: decode/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file
#(
  parameter bit WRITE_THROUGH = 1'b1
)
(
  input  wire                                  i_clk,
  input  wire                                  i_rst,
  input  wire  [mips_isa_pkg::NB_REG_ADDR-1:0] i_rd_addr1,
  input  wire  [mips_isa_pkg::NB_REG_ADDR-1:0] i_rd_addr2,
  input  wire                                  i_wr_en,
  input  wire  [mips_isa_pkg::NB_REG_ADDR-1:0] i_wr_addr,
  input  wire  [mips_isa_pkg::NB_DATA-1:0]     i_wr_data,
  output logic [mips_isa_pkg::NB_DATA-1:0]     o_rd_data1,
  output logic [mips_isa_pkg::NB_DATA-1:0]     o_rd_data2
);

  logic [mips_isa_pkg::NB_DATA-1:0] regs [mips_isa_pkg::N_REGS];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk)
  begin
    if (!i_rst)
    begin
      for (int idx = 0; idx < mips_isa_pkg::N_REGS; idx++)
      begin
        regs[idx] <= '0;
      end
    end
    // $zero is hardwired, writes to it are dropped
    else if (i_wr_en && (i_wr_addr != '0))
    begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [mips_isa_pkg::NB_DATA-1:0] read_port(
    input logic [mips_isa_pkg::NB_REG_ADDR-1:0] addr
  );
    logic bypass;
    bypass = WRITE_THROUGH && i_wr_en && (i_wr_addr == addr);
    if (addr == '0)
      return '0;
    else if (bypass)
      return i_wr_data;
    else
      return regs[addr];
  endfunction

  // Same-cycle write shows up here when bypass is enabled
  always_comb
  begin
    o_rd_data1 = read_port(i_rd_addr1);
    o_rd_data2 = read_port(i_rd_addr2);
  end

  // Register 0 stays zero whatever the write-back stage sends
  a_zero_reg_kept: assert property (
    @(posedge i_clk) disable iff (!i_rst)
    i_wr_en |=> (regs[0] == '0)
  ) else $error("reg_file: register 0 modified");

endmodule

`default_nettype wire

// File: decode/main_control.sv
`timescale 1ns/100ps
`default_nettype none

module main_control
(
  input  wire  [mips_isa_pkg::NB_OPCODE-1:0] i_opcode,
  input  wire  [mips_isa_pkg::NB_OPCODE-1:0] i_funct,
  output mips_ctrl_pkg::ctrl_t               o_ctrl,
  output logic                               o_zext_imm,
  output logic                               o_illegal
);

  mips_ctrl_pkg::ctrl_t ctrl;
  logic                 zext;
  logic                 illegal;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode and function decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    ctrl    = '0;
    zext    = 1'b0;
    illegal = 1'b0;

    case (i_opcode)
      mips_isa_pkg::OP_RTYPE:
      begin
        ctrl.ex.reg_dst   = 1'b1;
        ctrl.wb.reg_write = 1'b1;
        case (i_funct)
          mips_isa_pkg::FN_ADD: ctrl.ex.alu_op = mips_ctrl_pkg::ALU_ADD;
          mips_isa_pkg::FN_SUB: ctrl.ex.alu_op = mips_ctrl_pkg::ALU_SUB;
          mips_isa_pkg::FN_AND: ctrl.ex.alu_op = mips_ctrl_pkg::ALU_AND;
          mips_isa_pkg::FN_OR:  ctrl.ex.alu_op = mips_ctrl_pkg::ALU_OR;
          mips_isa_pkg::FN_XOR: ctrl.ex.alu_op = mips_ctrl_pkg::ALU_XOR;
          mips_isa_pkg::FN_NOR: ctrl.ex.alu_op = mips_ctrl_pkg::ALU_NOR;
          mips_isa_pkg::FN_SLT: ctrl.ex.alu_op = mips_ctrl_pkg::ALU_SLT;
          mips_isa_pkg::FN_SLL: ctrl.ex.alu_op = mips_ctrl_pkg::ALU_SLL;
          mips_isa_pkg::FN_SRL: ctrl.ex.alu_op = mips_ctrl_pkg::ALU_SRL;
          mips_isa_pkg::FN_SRA: ctrl.ex.alu_op = mips_ctrl_pkg::ALU_SRA;
          mips_isa_pkg::FN_JR:
          begin
            // Jump through rs with no write-back
            ctrl.wb.reg_write = 1'b0;
            ctrl.ex.jump_reg  = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end

      // Immediate arithmetic and logic
      mips_isa_pkg::OP_ADDI:
      begin
        ctrl.ex.alu_src   = 1'b1;
        ctrl.wb.reg_write = 1'b1;
        ctrl.ex.alu_op    = mips_ctrl_pkg::ALU_ADD;
      end
      mips_isa_pkg::OP_SLTI:
      begin
        ctrl.ex.alu_src   = 1'b1;
        ctrl.wb.reg_write = 1'b1;
        ctrl.ex.alu_op    = mips_ctrl_pkg::ALU_SLT;
      end
      mips_isa_pkg::OP_ANDI:
      begin
        ctrl.ex.alu_src   = 1'b1;
        ctrl.wb.reg_write = 1'b1;
        ctrl.ex.alu_op    = mips_ctrl_pkg::ALU_AND;
        zext              = 1'b1;
      end
      mips_isa_pkg::OP_ORI:
      begin
        ctrl.ex.alu_src   = 1'b1;
        ctrl.wb.reg_write = 1'b1;
        ctrl.ex.alu_op    = mips_ctrl_pkg::ALU_OR;
        zext              = 1'b1;
      end
      mips_isa_pkg::OP_XORI:
      begin
        ctrl.ex.alu_src   = 1'b1;
        ctrl.wb.reg_write = 1'b1;
        ctrl.ex.alu_op    = mips_ctrl_pkg::ALU_XOR;
        zext              = 1'b1;
      end
      mips_isa_pkg::OP_LUI:
      begin
        ctrl.ex.alu_src   = 1'b1;
        ctrl.wb.reg_write = 1'b1;
        ctrl.ex.alu_op    = mips_ctrl_pkg::ALU_LUI;
      end

      // Memory access at rs plus offset
      mips_isa_pkg::OP_LW:
      begin
        ctrl.ex.alu_src    = 1'b1;
        ctrl.mem.mem_read  = 1'b1;
        ctrl.wb.mem_to_reg = 1'b1;
        ctrl.wb.reg_write  = 1'b1;
        ctrl.ex.alu_op     = mips_ctrl_pkg::ALU_ADD;
      end
      mips_isa_pkg::OP_SW:
      begin
        ctrl.ex.alu_src    = 1'b1;
        ctrl.mem.mem_write = 1'b1;
        ctrl.ex.alu_op     = mips_ctrl_pkg::ALU_ADD;
      end

      // Branches compare by subtraction
      mips_isa_pkg::OP_BEQ:
      begin
        ctrl.ex.alu_src = 1'b1;
        ctrl.mem.branch = 1'b1;
        ctrl.ex.alu_op  = mips_ctrl_pkg::ALU_SUB;
      end
      mips_isa_pkg::OP_BNE:
      begin
        ctrl.ex.alu_src    = 1'b1;
        ctrl.mem.branch_ne = 1'b1;
        ctrl.ex.alu_op     = mips_ctrl_pkg::ALU_SUB;
      end

      mips_isa_pkg::OP_J: ctrl.ex.jump = 1'b1;

      default: illegal = 1'b1;
    endcase

    // Unknown codes decode as a bubble
    if (illegal)
    begin
      ctrl = '0;
      zext = 1'b0;
    end
  end

  assign o_ctrl     = ctrl;
  assign o_zext_imm = zext;
  assign o_illegal  = illegal;

  // Load and store exclusive for every decoded word
  always_comb
  begin
    a_no_load_store: assert (!(o_ctrl.mem.mem_read && o_ctrl.mem.mem_write))
      else $error("main_control: load and store decoded together");
  end

endmodule

`default_nettype wire

// File: decode/id_ex_register.sv
`timescale 1ns/100ps
`default_nettype none

module id_ex_register
(
  input  wire                              i_clk,
  input  wire                              i_rst,
  input  wire                              i_valid,
  input  wire  mips_isa_pkg::instr_u       i_instr,
  input  wire  [mips_isa_pkg::NB_DATA-1:0] i_pc_plus4,
  input  wire  [mips_isa_pkg::NB_DATA-1:0] i_dato1,
  input  wire  [mips_isa_pkg::NB_DATA-1:0] i_dato2,
  input  wire  mips_ctrl_pkg::ctrl_t       i_ctrl,
  input  wire                              i_zext_imm,
  input  wire                              i_illegal,
  input  wire                              i_stall,
  input  wire                              i_flush,
  output mips_ctrl_pkg::id_ex_t            o_id_ex
);

  localparam int NB_EXT = mips_isa_pkg::NB_DATA - mips_isa_pkg::NB_IMM;

  logic [mips_isa_pkg::NB_IMM-1:0]  imm;
  logic                             imm_msb;
  logic [mips_isa_pkg::NB_DATA-1:0] imm_ext;
  mips_ctrl_pkg::id_ex_t            id_ex_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Immediate extension
  ////////////////////////////////////////////////////////////////////////////
  assign imm     = i_instr.i_fmt.imm;
  // Logical immediates fill with zeros
  assign imm_msb = imm[mips_isa_pkg::NB_IMM-1] & ~i_zext_imm;
  assign imm_ext = {{NB_EXT{imm_msb}}, imm};

  ////////////////////////////////////////////////////////////////////////////
  // Next payload
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    id_ex_nxt          = '0;
    id_ex_nxt.valid    = i_valid;
    id_ex_nxt.illegal  = i_illegal;
    id_ex_nxt.pc_plus4 = i_pc_plus4;
    id_ex_nxt.rs       = i_instr.r_fmt.rs;
    id_ex_nxt.rt       = i_instr.r_fmt.rt;
    id_ex_nxt.rd       = i_instr.r_fmt.rd;
    id_ex_nxt.shamt    = i_instr.r_fmt.shamt;
    id_ex_nxt.dato1    = i_dato1;
    id_ex_nxt.dato2    = i_dato2;
    id_ex_nxt.imm_ext  = imm_ext;
    // No side effects downstream without a legal, valid instruction
    if (i_valid && !i_illegal)
      id_ex_nxt.ctrl = i_ctrl;
  end

  // Flush beats stall
  always_ff @(posedge i_clk)
  begin
    if (!i_rst)
      o_id_ex <= '0;
    else if (i_flush)
      o_id_ex <= '0;
    else if (!i_stall)
      o_id_ex <= id_ex_nxt;
  end

  // Bubbles carry no control
  a_bubble_no_ctrl: assert property (
    @(posedge i_clk) disable iff (!i_rst)
    !o_id_ex.valid |-> (o_id_ex.ctrl == '0)
  ) else $error("id_ex_register: control set on an invalid slot");

endmodule

`default_nettype wire

// File: decode/decode_top.sv
`timescale 1ns/100ps
`default_nettype none

module decode_top
#(
  parameter bit WRITE_THROUGH = 1'b1
)
(
  input  wire                                        i_clk,
  input  wire                                        i_rst,
  input  wire                                        i_valid,
  input  wire  mips_isa_pkg::instr_u                 i_instr,
  input  wire  [mips_isa_pkg::NB_DATA-1:0]           i_pc_plus4,
  input  wire                                        i_stall,
  input  wire                                        i_flush,
  input  wire                                        i_wb_en,
  input  wire  [mips_isa_pkg::NB_REG_ADDR-1:0]       i_wb_addr,
  input  wire  [mips_isa_pkg::NB_DATA-1:0]           i_wb_data,
  output mips_ctrl_pkg::id_ex_t                      o_id_ex
);

  logic [mips_isa_pkg::NB_DATA-1:0] rd_data1;
  logic [mips_isa_pkg::NB_DATA-1:0] rd_data2;
  mips_ctrl_pkg::ctrl_t             ctrl;
  logic                             zext_imm;
  logic                             illegal;

  // Operand read, write-back port shared with the last stage
  reg_file
  #(
    .WRITE_THROUGH (WRITE_THROUGH)
  )
  u_reg_file
  (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rd_addr1 (i_instr.r_fmt.rs),
    .i_rd_addr2 (i_instr.r_fmt.rt),
    .i_wr_en    (i_wb_en),
    .i_wr_addr  (i_wb_addr),
    .i_wr_data  (i_wb_data),
    .o_rd_data1 (rd_data1),
    .o_rd_data2 (rd_data2)
  );

  main_control u_main_control
  (
    .i_opcode   (i_instr.r_fmt.opcode),
    .i_funct    (i_instr.r_fmt.funct),
    .o_ctrl     (ctrl),
    .o_zext_imm (zext_imm),
    .o_illegal  (illegal)
  );

  id_ex_register u_id_ex_register
  (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (i_valid),
    .i_instr    (i_instr),
    .i_pc_plus4 (i_pc_plus4),
    .i_dato1    (rd_data1),
    .i_dato2    (rd_data2),
    .i_ctrl     (ctrl),
    .i_zext_imm (zext_imm),
    .i_illegal  (illegal),
    .i_stall    (i_stall),
    .i_flush    (i_flush),
    .o_id_ex    (o_id_ex)
  );

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen
#(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 10
)
(
  output logic o_clk,
  output logic o_rst
);

  initial
  begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Active low reset, released on a rising edge
  initial
  begin
    o_rst = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst <= 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/decode_checker.sv
`timescale 1ns/100ps
`default_nettype none

module decode_checker
#(
  parameter bit WRITE_THROUGH = 1'b1
)
(
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire                        i_valid,
  input  wire  [31:0]                i_instr,
  input  wire  [31:0]                i_pc_plus4,
  input  wire                        i_stall,
  input  wire                        i_flush,
  input  wire                        i_wb_en,
  input  wire  [4:0]                 i_wb_addr,
  input  wire  [31:0]                i_wb_data,
  input  wire  mips_ctrl_pkg::id_ex_t i_id_ex,
  input  wire  mips_ctrl_pkg::ctrl_t  i_exp_ctrl,
  input  wire                        i_exp_illegal,
  input  wire                        i_exp_zext,
  output int                         o_checks,
  output int                         o_mismatches
);

  logic [31:0]           model [32];
  mips_ctrl_pkg::id_ex_t exp_q;
  logic                  armed = 1'b0;
  int                    checks = 0;
  int                    mismatches = 0;

  assign o_checks     = checks;
  assign o_mismatches = mismatches;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  // Register 0 reads as zero and bypass returns a same-cycle write
  function automatic logic [31:0] model_read(input logic [4:0] addr);
    if (addr == 5'd0)
      return 32'h0;
    if (WRITE_THROUGH && i_wb_en && (i_wb_addr == addr))
      return i_wb_data;
    return model[addr];
  endfunction

  function automatic mips_ctrl_pkg::id_ex_t build_expected();
    mips_ctrl_pkg::id_ex_t e;
    logic [15:0]           imm;
    imm        = i_instr[15:0];
    e          = '0;
    e.valid    = i_valid;
    e.illegal  = i_exp_illegal;
    e.pc_plus4 = i_pc_plus4;
    e.rs       = i_instr[25:21];
    e.rt       = i_instr[20:16];
    e.rd       = i_instr[15:11];
    e.shamt    = i_instr[10:6];
    e.dato1    = model_read(i_instr[25:21]);
    e.dato2    = model_read(i_instr[20:16]);
    e.imm_ext  = i_exp_zext ? {16'h0, imm} : {{16{imm[15]}}, imm};
    if (i_valid && !i_exp_illegal)
      e.ctrl = i_exp_ctrl;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////
  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_all();
    compare_field("valid", 32'(i_id_ex.valid), 32'(exp_q.valid));
    compare_field("illegal", 32'(i_id_ex.illegal), 32'(exp_q.illegal));
    compare_field("pc_plus4", i_id_ex.pc_plus4, exp_q.pc_plus4);
    compare_field("rs", 32'(i_id_ex.rs), 32'(exp_q.rs));
    compare_field("rt", 32'(i_id_ex.rt), 32'(exp_q.rt));
    compare_field("rd", 32'(i_id_ex.rd), 32'(exp_q.rd));
    compare_field("shamt", 32'(i_id_ex.shamt), 32'(exp_q.shamt));
    compare_field("dato1", i_id_ex.dato1, exp_q.dato1);
    compare_field("dato2", i_id_ex.dato2, exp_q.dato2);
    compare_field("imm_ext", i_id_ex.imm_ext, exp_q.imm_ext);
    compare_field("ctrl.wb", 32'(i_id_ex.ctrl.wb), 32'(exp_q.ctrl.wb));
    compare_field("ctrl.mem", 32'(i_id_ex.ctrl.mem), 32'(exp_q.ctrl.mem));
    compare_field("ctrl.ex", 32'(i_id_ex.ctrl.ex), 32'(exp_q.ctrl.ex));
  endtask

  // Inputs seen here are the ones captured at the next rising edge
  always @(negedge i_clk)
  begin
    if (armed)
      compare_all();
    if (!i_rst)
    begin
      exp_q = '0;
      for (int idx = 0; idx < 32; idx++)
        model[idx] = 32'h0;
      armed = 1'b1;
    end
    else
    begin
      if (i_flush)
        exp_q = '0;
      else if (!i_stall)
        exp_q = build_expected();
      if (i_wb_en && (i_wb_addr != 5'd0))
        model[i_wb_addr] = i_wb_data;
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_decode.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decode;

  localparam bit WRITE_THROUGH = 1'b1;
  localparam int RST_CYCLES    = 10;

  // Valid, stall, flush
  localparam logic [2:0] V   = 3'b100;
  localparam logic [2:0] NV  = 3'b000;
  localparam logic [2:0] VS  = 3'b110;
  localparam logic [2:0] VSF = 3'b111;
  localparam logic [2:0] VF  = 3'b101;

  // Control flags as wb(2) mem(4) ex(4) without the ALU op
  localparam logic [9:0] F_R   = 10'b10_0000_1000;
  localparam logic [9:0] F_JR  = 10'b00_0000_1001;
  localparam logic [9:0] F_I   = 10'b10_0000_0100;
  localparam logic [9:0] F_LW  = 10'b11_0010_0100;
  localparam logic [9:0] F_SW  = 10'b00_0001_0100;
  localparam logic [9:0] F_BEQ = 10'b00_1000_0100;
  localparam logic [9:0] F_BNE = 10'b00_0100_0100;
  localparam logic [9:0] F_J   = 10'b00_0000_0010;
  localparam logic [9:0] F_NO  = 10'b00_0000_0000;

  typedef struct packed {
    logic [31:0]          instr;
    logic                 valid;
    logic                 stall;
    logic                 flush;
    logic                 wb_en;
    logic [4:0]           wb_addr;
    logic [31:0]          wb_data;
    mips_ctrl_pkg::ctrl_t exp_ctrl;
    logic                 exp_illegal;
    logic                 exp_zext;
  } row_t;

  row_t                  rows[$];
  logic [31:0]           lcg_state = 32'd87;
  int                    cycles = 0;
  int                    limit = 0;
  int                    timeouts = 0;
  int                    checks;
  int                    mismatches;
  logic                  clk;
  logic                  rst;
  logic                  valid;
  mips_isa_pkg::instr_u  instr;
  logic [31:0]           pc_plus4;
  logic                  stall;
  logic                  flush;
  logic                  wb_en;
  logic [4:0]            wb_addr;
  logic [31:0]           wb_data;
  mips_ctrl_pkg::id_ex_t id_ex;
  mips_ctrl_pkg::ctrl_t  exp_ctrl;
  logic                  exp_illegal;
  logic                  exp_zext;

  tb_clkgen #(.PERIOD_NS(40), .RST_CYCLES(RST_CYCLES)) u_clkgen (.o_clk(clk), .o_rst(rst));

  decode_top #(.WRITE_THROUGH(WRITE_THROUGH)) dut0
  (
    .i_clk      (clk),
    .i_rst      (rst),
    .i_valid    (valid),
    .i_instr    (instr),
    .i_pc_plus4 (pc_plus4),
    .i_stall    (stall),
    .i_flush    (flush),
    .i_wb_en    (wb_en),
    .i_wb_addr  (wb_addr),
    .i_wb_data  (wb_data),
    .o_id_ex    (id_ex)
  );

  decode_checker #(.WRITE_THROUGH(WRITE_THROUGH)) u_checker
  (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_valid       (valid),
    .i_instr       (instr),
    .i_pc_plus4    (pc_plus4),
    .i_stall       (stall),
    .i_flush       (flush),
    .i_wb_en       (wb_en),
    .i_wb_addr     (wb_addr),
    .i_wb_data     (wb_data),
    .i_id_ex       (id_ex),
    .i_exp_ctrl    (exp_ctrl),
    .i_exp_illegal (exp_illegal),
    .i_exp_zext    (exp_zext),
    .o_checks      (checks),
    .o_mismatches  (mismatches)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Table helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] reg_instr(input int rs, input int rt, input int rd,
                                            input int sh, input logic [5:0] fn);
    return {mips_isa_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
  endfunction

  function automatic logic [31:0] imm_instr(input logic [5:0] op, input int rs,
                                            input int rt, input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  // A negative write address means no register write that cycle
  task automatic add_row(input logic [31:0] word, input logic [2:0] vsf, input int wr_addr,
                         input logic [9:0] flags, input logic [3:0] op,
                         input logic illegal, input logic zext);
    row_t r;
    r.instr                     = word;
    {r.valid, r.stall, r.flush} = vsf;
    r.wb_en                     = (wr_addr >= 0);
    r.wb_addr                   = wr_addr[4:0];
    r.wb_data                   = 32'h0;
    if (r.wb_en)
      r.wb_data = lcg_next();
    r.exp_ctrl    = mips_ctrl_pkg::ctrl_t'({flags, op});
    r.exp_illegal = illegal;
    r.exp_zext    = zext;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Read sweep over all registers right after reset
    for (int k = 0; k < 16; k++)
      add_row(reg_instr(2 * k, 2 * k + 1, k, k, mips_isa_pkg::FN_ADD), V, -1,
              F_R, mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
    add_row(reg_instr(0, 1, 2, 5, mips_isa_pkg::FN_SLL), V, 1, F_R, mips_ctrl_pkg::ALU_SLL,
            1'b0, 1'b0);
    add_row(reg_instr(0, 1, 3, 31, mips_isa_pkg::FN_SRL), V, 2, F_R, mips_ctrl_pkg::ALU_SRL,
            1'b0, 1'b0);
    add_row(reg_instr(0, 2, 4, 17, mips_isa_pkg::FN_SRA), V, 3, F_R, mips_ctrl_pkg::ALU_SRA,
            1'b0, 1'b0);
    add_row(reg_instr(1, 2, 5, 0, mips_isa_pkg::FN_ADD), V, 4, F_R, mips_ctrl_pkg::ALU_ADD,
            1'b0, 1'b0);
    // Write and read of r5 in one cycle
    add_row(reg_instr(3, 5, 6, 0, mips_isa_pkg::FN_SUB), V, 5, F_R, mips_ctrl_pkg::ALU_SUB,
            1'b0, 1'b0);
    add_row(reg_instr(4, 5, 7, 0, mips_isa_pkg::FN_AND), V, 6, F_R, mips_ctrl_pkg::ALU_AND,
            1'b0, 1'b0);
    add_row(reg_instr(6, 1, 8, 0, mips_isa_pkg::FN_OR), V, 7, F_R, mips_ctrl_pkg::ALU_OR,
            1'b0, 1'b0);
    add_row(reg_instr(7, 2, 9, 0, mips_isa_pkg::FN_XOR), V, 8, F_R, mips_ctrl_pkg::ALU_XOR,
            1'b0, 1'b0);
    add_row(reg_instr(8, 3, 10, 0, mips_isa_pkg::FN_NOR), V, 0, F_R, mips_ctrl_pkg::ALU_NOR,
            1'b0, 1'b0);
    // $zero written and read together stays zero
    add_row(reg_instr(0, 8, 11, 0, mips_isa_pkg::FN_SLT), V, 0, F_R, mips_ctrl_pkg::ALU_SLT,
            1'b0, 1'b0);
    add_row(reg_instr(1, 0, 0, 0, mips_isa_pkg::FN_JR), V, -1, F_JR, mips_ctrl_pkg::ALU_ADD,
            1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_ADDI, 1, 9, 'h8000), V, 9, F_I,
            mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_SLTI, 2, 10, 'h7fff), V, 10, F_I,
            mips_ctrl_pkg::ALU_SLT, 1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_ANDI, 3, 11, 'h8001), V, 11, F_I,
            mips_ctrl_pkg::ALU_AND, 1'b0, 1'b1);
    add_row(imm_instr(mips_isa_pkg::OP_ORI, 4, 12, 'hf00f), V, 12, F_I,
            mips_ctrl_pkg::ALU_OR, 1'b0, 1'b1);
    add_row(imm_instr(mips_isa_pkg::OP_XORI, 5, 13, 'h1234), V, 13, F_I,
            mips_ctrl_pkg::ALU_XOR, 1'b0, 1'b1);
    add_row(imm_instr(mips_isa_pkg::OP_LUI, 0, 14, 'hbeef), V, -1, F_I,
            mips_ctrl_pkg::ALU_LUI, 1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_LW, 6, 15, 'hfffc), V, -1, F_LW,
            mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_SW, 7, 8, 'h0010), V, -1, F_SW,
            mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_BEQ, 8, 9, 'h8004), V, -1, F_BEQ,
            mips_ctrl_pkg::ALU_SUB, 1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_BNE, 9, 1, 'h0004), V, -1, F_BNE,
            mips_ctrl_pkg::ALU_SUB, 1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_J, 1, 2, 'h3456), V, -1, F_J,
            mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
    // Unknown codes
    add_row(imm_instr(6'h3f, 1, 2, 'h8000), V, -1, F_NO, 4'h0, 1'b1, 1'b0);
    add_row(reg_instr(1, 2, 3, 4, 6'h3f), V, -1, F_NO, 4'h0, 1'b1, 1'b0);
    add_row(imm_instr(6'h01, 3, 4, 'h0042), V, -1, F_NO, 4'h0, 1'b1, 1'b0);
    // Slot without a valid instruction
    add_row(reg_instr(4, 5, 6, 0, mips_isa_pkg::FN_ADD), NV, -1, F_R,
            mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
    // Stall with writes still going on
    add_row(imm_instr(mips_isa_pkg::OP_ADDI, 2, 3, 'h0001), VS, 1, F_I,
            mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_ORI, 4, 5, 'h0002), VS, 2, F_I,
            mips_ctrl_pkg::ALU_OR, 1'b0, 1'b1);
    add_row(reg_instr(6, 7, 8, 3, mips_isa_pkg::FN_SRL), VS, -1, F_R,
            mips_ctrl_pkg::ALU_SRL, 1'b0, 1'b0);
    add_row(reg_instr(1, 2, 3, 0, mips_isa_pkg::FN_ADD), V, -1, F_R,
            mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_LW, 6, 7, 'h8008), VSF, -1, F_LW,
            mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
    add_row(imm_instr(mips_isa_pkg::OP_SW, 8, 9, 'h0008), VF, -1, F_SW,
            mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
    add_row(reg_instr(4, 5, 6, 0, mips_isa_pkg::FN_ADD), V, 5, F_R,
            mips_ctrl_pkg::ALU_ADD, 1'b0, 1'b0);
  endtask

  task automatic finish_run();
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
    if ((mismatches == 0) && (timeouts == 0) && (checks > 0))
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    valid       = 1'b0;
    instr       = '0;
    pc_plus4    = 32'h0;
    stall       = 1'b0;
    flush       = 1'b0;
    wb_en       = 1'b0;
    wb_addr     = 5'd0;
    wb_data     = 32'h0;
    exp_ctrl    = '0;
    exp_illegal = 1'b0;
    exp_zext    = 1'b0;
    build_table();
    limit = RST_CYCLES + rows.size() + 20;
    wait (rst === 1'b1);
    foreach (rows[idx])
    begin
      @(posedge clk);
      instr       <= mips_isa_pkg::instr_u'(rows[idx].instr);
      valid       <= rows[idx].valid;
      stall       <= rows[idx].stall;
      flush       <= rows[idx].flush;
      wb_en       <= rows[idx].wb_en;
      wb_addr     <= rows[idx].wb_addr;
      wb_data     <= rows[idx].wb_data;
      pc_plus4    <= 32'h0040_0004 + 32'(4 * idx);
      exp_ctrl    <= rows[idx].exp_ctrl;
      exp_illegal <= rows[idx].exp_illegal;
      exp_zext    <= rows[idx].exp_zext;
    end
    @(posedge clk);
    valid <= 1'b0;
    stall <= 1'b0;
    flush <= 1'b0;
    wb_en <= 1'b0;
    // Last capture is compared on the following falling edge
    repeat (3) @(posedge clk);
    finish_run();
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if ((limit > 0) && (cycles >= limit))
    begin
      timeouts = timeouts + 1;
      $display("ERROR: test timed out after %0d cycles before the table finished", cycles);
      finish_run();
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
common/mips_isa_pkg.sv
common/mips_ctrl_pkg.sv
decode/reg_file.sv
decode/main_control.sv
decode/id_ex_register.sv
decode/decode_top.sv
dv/tb_clkgen.sv
dv/decode_checker.sv
dv/tb_decode.sv
